/* verilog/gmii_udp_tx_pkg.sv */
`default_nettype none

package gmii_udp_tx_pkg;

	//--------------------------------------------------------------------------
	// Header fields
	//--------------------------------------------------------------------------
	localparam logic [47:0] SRC_MAC      = 48'h00_23_45_67_89_01;	// Last byte + station_id
	localparam logic [47:0] DST_MAC      = 48'h00_23_45_67_89_02;	// Last byte - station_id
	localparam logic [15:0] ETH_TYPE     = 16'h0800;	// IPv4
	localparam logic [15:0] IP_VER_TOS   = 16'h4500;	// v4, 20 byte header, TOS 0
	localparam logic [15:0] IP_TOTAL_LEN = 16'd1312;	// 20 + 8 + 4 + 1280
	localparam logic [15:0] IP_IDEN      = 16'h0000;
	localparam logic [15:0] IP_FLAGS     = 16'h4000;	// Don't fragment
	localparam logic [7:0]  IP_TTL       = 8'h40;
	localparam logic [7:0]  IP_PROTO     = 8'h11;	// UDP
	localparam logic [31:0] IP_SRC_ADDR  = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] IP_DST_ADDR  = {8'd192, 8'd168, 8'd0, 8'd2};
	localparam logic [15:0] UDP_SRC_PORT = 16'd12344;
	localparam logic [15:0] UDP_DST_PORT = 16'd12345;
	localparam logic [15:0] UDP_LEN      = 16'd1292;	// 8 + 4 + 1280

	//--------------------------------------------------------------------------
	// Frame layout, in bytes or cycles
	//--------------------------------------------------------------------------
	localparam int PREAMBLE_BYTES  = 7;	// 0x55, SFD comes after
	localparam int HEADER_BYTES    = 42;	// Eth 14, IP 20, UDP 8
	localparam int COORD_BYTES     = 4;
	localparam int PAYLOAD_BYTES   = 1280;	// 640 pixel words
	localparam int FCS_BYTES       = 4;
	localparam int IFG_CYCLES      = 12;
	localparam int FRAMES_PER_LINE = 2;

	localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;	// 802.3 poly, reflected

	// Sequencer FSM encoding
	localparam logic [2:0] ST_IDLE     = 3'd0;
	localparam logic [2:0] ST_PREAMBLE = 3'd1;
	localparam logic [2:0] ST_SFD      = 3'd2;
	localparam logic [2:0] ST_HEADER   = 3'd3;
	localparam logic [2:0] ST_COORD    = 3'd4;
	localparam logic [2:0] ST_PAYLOAD  = 3'd5;
	localparam logic [2:0] ST_FCS_WAIT = 3'd6;
	localparam logic [2:0] ST_GAP      = 3'd7;

	// First word of a line
	typedef struct packed {
		logic [15:0] line_y;
		logic [15:0] line_x;
		logic [15:0] spare;
	} coord_word_t;

	// Pixel words, YUV and raw lanes side by side
	typedef struct packed {
		logic [7:0]  luma;
		logic [7:0]  chroma;
		logic [7:0]  green;
		logic [7:0]  red;
		logic [15:0] spare;
	} pixel_word_t;

	typedef union packed {
		coord_word_t coord;
		pixel_word_t pixel;
	} fifo_word_u;

	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       sfd;	// Start frame delimiter
		logic       last_body;	// FCS follows this byte
	} tx_byte_t;

	typedef logic [5:0] hdr_index_t;

endpackage

`default_nettype wire

/* verilog/fifo_word_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module fifo_word_decode (
	input  gmii_udp_tx_pkg::fifo_word_u fifo_dout,	// Head of show-ahead FIFO
	input  logic                        mode,	// 0 YUV422, 1 raw
	input  logic [2:0]                  byte_sel,	// 0..3 coord, 4..5 pixel
	output logic [7:0]                  payload_byte
);

	//--------------------------------------------------------------------------
	// Byte select over both views of the word
	//--------------------------------------------------------------------------
	always_comb begin
		case (byte_sel)
			// Coordinates, Y first, network order
			3'd0: payload_byte = fifo_dout.coord.line_y[15:8];
			3'd1: payload_byte = fifo_dout.coord.line_y[7:0];
			3'd2: payload_byte = fifo_dout.coord.line_x[15:8];
			3'd3: payload_byte = fifo_dout.coord.line_x[7:0];
			// First pixel byte
			3'd4: begin
				if (mode)
					payload_byte = fifo_dout.pixel.green;
				else
					payload_byte = fifo_dout.pixel.luma;
			end
			// Second pixel byte
			3'd5: begin
				if (mode)
					payload_byte = fifo_dout.pixel.red;
				else
					payload_byte = fifo_dout.pixel.chroma;	// Cb or Cr, alternating
			end
			default: payload_byte = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/ip_header_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module ip_header_gen (
	input  logic                        fifo_clk,
	input  logic                        sys_rst,
	input  logic                        frame_start,	// One cycle, from sequencer
	input  logic                        station_id,
	input  gmii_udp_tx_pkg::hdr_index_t hdr_index,
	output logic [7:0]                  hdr_byte
);
	import gmii_udp_tx_pkg::*;

	logic                      id_q;	// Station id for this frame
	logic [15:0]               ip_csum_q;
	logic [31:0]               src_ip_now;
	logic [31:0]               dst_ip_now;
	logic [19:0]               csum_sum;	// Room for nine carries
	logic [16:0]               csum_fold1;
	logic [15:0]               csum_fold2;
	logic [31:0]               src_ip;
	logic [31:0]               dst_ip;
	logic [HEADER_BYTES*8-1:0] hdr_vec;	// Byte 0 in the top bits

	//--------------------------------------------------------------------------
	// IPv4 checksum for the station id at frame start
	//--------------------------------------------------------------------------
	assign src_ip_now = {IP_SRC_ADDR[31:8], IP_SRC_ADDR[7:0] + {7'd0, station_id}};
	assign dst_ip_now = {IP_DST_ADDR[31:8], IP_DST_ADDR[7:0] - {7'd0, station_id}};

	// Checksum field itself counts as zero
	assign csum_sum = {4'd0, IP_VER_TOS} + {4'd0, IP_TOTAL_LEN} + {4'd0, IP_IDEN} +
		{4'd0, IP_FLAGS} + {4'd0, IP_TTL, IP_PROTO} +
		{4'd0, src_ip_now[31:16]} + {4'd0, src_ip_now[15:0]} +
		{4'd0, dst_ip_now[31:16]} + {4'd0, dst_ip_now[15:0]};

	// Fold twice, the first fold can carry again
	assign csum_fold1 = {1'b0, csum_sum[15:0]} + {13'd0, csum_sum[19:16]};
	assign csum_fold2 = csum_fold1[15:0] + {15'd0, csum_fold1[16]};

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			id_q      <= 1'b0;
			ip_csum_q <= 16'h0000;
		end else if (frame_start) begin
			id_q      <= station_id;
			ip_csum_q <= ~csum_fold2;	// One's complement of the sum
		end
	end

	//--------------------------------------------------------------------------
	// Header bytes
	//--------------------------------------------------------------------------
	assign src_ip = {IP_SRC_ADDR[31:8], IP_SRC_ADDR[7:0] + {7'd0, id_q}};
	assign dst_ip = {IP_DST_ADDR[31:8], IP_DST_ADDR[7:0] - {7'd0, id_q}};

	assign hdr_vec = {
		DST_MAC[47:8], DST_MAC[7:0] - {7'd0, id_q},	// Ethernet, 14 bytes
		SRC_MAC[47:8], SRC_MAC[7:0] + {7'd0, id_q},
		ETH_TYPE,
		IP_VER_TOS, IP_TOTAL_LEN, IP_IDEN, IP_FLAGS,	// IPv4, 20 bytes
		IP_TTL, IP_PROTO, ip_csum_q,
		src_ip, dst_ip,
		UDP_SRC_PORT, UDP_DST_PORT, UDP_LEN,	// UDP, 8 bytes
		16'h0000	// No UDP checksum
	};

	always_comb begin
		hdr_byte = 8'h00;
		if (hdr_index < HEADER_BYTES)
			hdr_byte = hdr_vec[(HEADER_BYTES - 1 - hdr_index) * 8 +: 8];
	end

endmodule

`default_nettype wire

/* verilog/frame_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_sequencer (
	input  logic                        fifo_clk,
	input  logic                        sys_rst,
	input  logic                        fifo_empty,
	input  logic                        fifo_wr_en,	// Line writer strobe
	output logic                        fifo_rd_en,	// Pop, one per word
	output logic                        frame_start,
	output gmii_udp_tx_pkg::hdr_index_t hdr_index,
	input  logic [7:0]                  hdr_byte,
	output logic [2:0]                  byte_sel,
	input  logic [7:0]                  payload_byte,
	output gmii_udp_tx_pkg::tx_byte_t   body_byte	// Registered, no stall
);
	import gmii_udp_tx_pkg::*;

	logic [2:0]  state;
	logic [10:0] count;	// Byte index inside the state
	logic        wr_en_q;
	logic        wr_en_fall;
	logic        send_en;
	logic [1:0]  frame_cnt;	// Frames started since the line

	//--------------------------------------------------------------------------
	// Two-frame enable per line write
	//--------------------------------------------------------------------------
	assign wr_en_fall  = wr_en_q & ~fifo_wr_en;
	assign frame_start = (state == ST_IDLE) & send_en & ~fifo_empty;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_en_q   <= 1'b0;
			send_en   <= 1'b0;
			frame_cnt <= 2'd0;
		end else begin
			wr_en_q <= fifo_wr_en;
			if (frame_start) begin
				if (frame_cnt == 2'(FRAMES_PER_LINE - 1)) begin
					send_en   <= 1'b0;	// Last frame of this line
					frame_cnt <= 2'd0;
				end else begin
					frame_cnt <= frame_cnt + 2'd1;
				end
			end
			// A new line re-arms, wins over the count
			if (wr_en_fall) begin
				send_en   <= 1'b1;
				frame_cnt <= 2'd0;
			end
		end
	end

	//--------------------------------------------------------------------------
	// Lookups and pops, all from the current state
	//--------------------------------------------------------------------------
	assign hdr_index = count[5:0];
	assign byte_sel  = (state == ST_PAYLOAD) ? {2'b10, count[0]} : count[2:0];

	// Coord word goes after its last byte, pixel words after the second byte
	assign fifo_rd_en = ((state == ST_COORD) & (count == 11'(COORD_BYTES - 1))) |
		((state == ST_PAYLOAD) & count[0]);

	//--------------------------------------------------------------------------
	// Frame FSM
	//--------------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state     <= ST_IDLE;
			count     <= 11'd0;
			body_byte <= '0;
		end else begin
			body_byte <= '0;	// Invalid unless a state sends
			count     <= count + 11'd1;
			case (state)
				ST_IDLE: begin
					count <= 11'd1;	// Preamble byte 0 leaves from here
					if (frame_start) begin
						body_byte.data  <= 8'h55;
						body_byte.valid <= 1'b1;
						state           <= ST_PREAMBLE;
					end
				end
				ST_PREAMBLE: begin
					body_byte.data  <= 8'h55;
					body_byte.valid <= 1'b1;
					if (count == 11'(PREAMBLE_BYTES - 1))
						state <= ST_SFD;
				end
				ST_SFD: begin
					body_byte.data  <= 8'hD5;
					body_byte.valid <= 1'b1;
					body_byte.sfd   <= 1'b1;	// CRC starts after this
					state           <= ST_HEADER;
					count           <= 11'd0;
				end
				ST_HEADER: begin
					body_byte.data  <= hdr_byte;
					body_byte.valid <= 1'b1;
					if (count == 11'(HEADER_BYTES - 1)) begin
						state <= ST_COORD;
						count <= 11'd0;
					end
				end
				ST_COORD: begin
					body_byte.data  <= payload_byte;
					body_byte.valid <= 1'b1;
					if (count == 11'(COORD_BYTES - 1)) begin
						state <= ST_PAYLOAD;
						count <= 11'd0;
					end
				end
				ST_PAYLOAD: begin
					body_byte.data  <= payload_byte;
					body_byte.valid <= 1'b1;
					if (count == 11'(PAYLOAD_BYTES - 1)) begin
						body_byte.last_body <= 1'b1;
						state               <= ST_FCS_WAIT;
						count               <= 11'd0;
					end
				end
				// fcs_append owns the line for four cycles
				ST_FCS_WAIT: begin
					if (count == 11'(FCS_BYTES - 1)) begin
						state <= ST_GAP;
						count <= 11'd0;
					end
				end
				ST_GAP: begin
					if (count == 11'(IFG_CYCLES - 1)) begin
						state <= ST_IDLE;
						count <= 11'd0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/fcs_append.sv */
`timescale 1ns/100ps
`default_nettype none

module fcs_append (
	input  logic                      fifo_clk,
	input  logic                      sys_rst,
	input  gmii_udp_tx_pkg::tx_byte_t body_byte,
	output logic                      tx_en,
	output logic [7:0]                txd
);
	import gmii_udp_tx_pkg::*;

	logic [31:0] crc;
	logic [31:0] crc_nxt;
	logic [31:0] fcs_word;
	logic        fcs_busy;	// Sending the four FCS bytes
	logic [1:0]  fcs_cnt;

	// Bytewise CRC-32, LSB first as on the wire
	function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
		input logic [7:0] data);
		logic [31:0] c;
		c = crc_in;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ data[i])
				c = (c >> 1) ^ CRC_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	assign crc_nxt  = crc32_byte(crc, body_byte.data);
	assign fcs_word = ~crc;	// Reflected form, low byte goes out first

	//--------------------------------------------------------------------------
	// CRC over the body, restarted on SFD
	//--------------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (body_byte.valid) begin
			if (body_byte.sfd)
				crc <= CRC_INIT;
			else
				crc <= crc_nxt;
		end
	end

	//--------------------------------------------------------------------------
	// GMII output register
	//--------------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			tx_en    <= 1'b0;
			txd      <= 8'h00;
			fcs_busy <= 1'b0;
			fcs_cnt  <= 2'd0;
		end else begin
			if (fcs_busy) begin
				tx_en   <= 1'b1;
				txd     <= fcs_word[{fcs_cnt, 3'b000} +: 8];
				fcs_cnt <= fcs_cnt + 2'd1;
				if (fcs_cnt == 2'(FCS_BYTES - 1))
					fcs_busy <= 1'b0;
			end else begin
				tx_en <= body_byte.valid;
				txd   <= body_byte.valid ? body_byte.data : 8'h00;	// Idle low
			end
			if (body_byte.valid & body_byte.last_body) begin
				fcs_busy <= 1'b1;	// CRC is complete next cycle
				fcs_cnt  <= 2'd0;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/gmii_udp_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module gmii_udp_tx (
	input  logic                        fifo_clk,
	input  logic                        sys_rst,
	input  logic                        station_id,	// Address offset
	input  logic                        mode,	// 0 YUV422, 1 raw
	input  gmii_udp_tx_pkg::fifo_word_u fifo_dout,
	input  logic                        fifo_empty,
	input  logic                        fifo_wr_en,
	output logic                        fifo_rd_en,
	output logic                        tx_en,
	output logic [7:0]                  txd
);
	import gmii_udp_tx_pkg::*;

	hdr_index_t hdr_index;
	logic [7:0] hdr_byte;
	logic [2:0] byte_sel;
	logic [7:0] payload_byte;
	logic       frame_start;
	tx_byte_t   body_byte;	// Sequencer to FCS stage

	fifo_word_decode fifo_word_decode_inst (.fifo_dout, .mode, .byte_sel, .payload_byte);

	ip_header_gen ip_header_gen_inst (.fifo_clk, .sys_rst, .frame_start, .station_id,
		.hdr_index, .hdr_byte);

	frame_sequencer frame_sequencer_inst (.fifo_clk, .sys_rst, .fifo_empty, .fifo_wr_en,
		.fifo_rd_en, .frame_start, .hdr_index, .hdr_byte, .byte_sel, .payload_byte,
		.body_byte);

	fcs_append fcs_append_inst (.fifo_clk, .sys_rst, .body_byte, .tx_en, .txd);

endmodule

`default_nettype wire

/* tb/gmii_udp_tx_props.sv */
`timescale 1ns/100ps
`default_nettype none

module gmii_udp_tx_props (
	input logic fifo_clk,
	input logic sys_rst,
	input logic fifo_empty,
	input logic fifo_rd_en,
	input logic tx_en
);
	import gmii_udp_tx_pkg::*;

	int         assert_fails = 0;	// Failure tally
	logic [7:0] low_cycles;	// Idle cycles since tx_en fell, saturating

	always_ff @(posedge fifo_clk) begin
		if (sys_rst)
			low_cycles <= 8'(IFG_CYCLES);
		else if (tx_en)
			low_cycles <= 8'd0;
		else if (low_cycles != 8'hFF)
			low_cycles <= low_cycles + 8'd1;
	end

	//--------------------------------------------------------------------------
	// FIFO side and GMII framing
	//--------------------------------------------------------------------------
	no_pop_when_empty: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		fifo_rd_en |-> !fifo_empty)
		else begin
			$error("fifo_rd_en asserted while fifo_empty is high");
			assert_fails++;
		end

	// Gap before every new frame
	ifg_kept: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$rose(tx_en) |-> low_cycles >= 8'(IFG_CYCLES))
		else begin
			$error("tx_en rose after only %0d idle cycles", low_cycles);
			assert_fails++;
		end

	after_reset_idle: assert property (@(posedge fifo_clk)
		sys_rst |=> (!tx_en && !fifo_rd_en))
		else begin
			$error("tx_en or fifo_rd_en high right after reset");
			assert_fails++;
		end

endmodule

bind gmii_udp_tx gmii_udp_tx_props gmii_udp_tx_props_inst (
	.fifo_clk(fifo_clk),
	.sys_rst(sys_rst),
	.fifo_empty(fifo_empty),
	.fifo_rd_en(fifo_rd_en),
	.tx_en(tx_en)
);

`default_nettype wire

/* tb/gmii_udp_tx_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module gmii_udp_tx_tb;
	import gmii_udp_tx_pkg::*;

	logic       fifo_clk;
	logic       sys_rst;
	logic       station_id;
	logic       mode;
	fifo_word_u fifo_dout;
	logic       fifo_empty;
	logic       fifo_wr_en;
	logic       fifo_rd_en;
	logic       tx_en;
	logic [7:0] txd;

	fifo_word_u fifo_q[$];	// FIFO contents
	fifo_word_u exp_q[$];	// Same words, consumed by the checker
	fifo_word_u popped_q[$];
	fifo_word_u cur_words[$];	// Words of the frame under check
	logic [7:0] rx_bytes[$];
	logic [7:0] exp_bytes[$];	// Preamble up to last payload byte
	integer     seed;
	int         cyc;
	int         value_errs;
	int         other_errs;

	gmii_udp_tx gmii_udp_tx_inst (.fifo_clk, .sys_rst, .station_id, .mode, .fifo_dout,
		.fifo_empty, .fifo_wr_en, .fifo_rd_en, .tx_en, .txd);

	initial begin
		fifo_clk = 1'b0;
		forever #10 fifo_clk = ~fifo_clk;
	end

	//--------------------------------------------------------------------------
	// Show-ahead FIFO model and cycle count
	//--------------------------------------------------------------------------
	always @(posedge fifo_clk) begin
		cyc <= cyc + 1;
		if (fifo_rd_en && fifo_q.size() > 0)
			popped_q.push_back(fifo_q.pop_front());
		fifo_empty <= (fifo_q.size() == 0);
		if (fifo_q.size() > 0)
			fifo_dout <= fifo_q[0];	// New head right after a pop
		else
			fifo_dout <= '0;
	end

	function automatic int frame_len();
		return PREAMBLE_BYTES + 1 + HEADER_BYTES + COORD_BYTES + PAYLOAD_BYTES + FCS_BYTES;
	endfunction

	function automatic int words_per_frame();
		return 1 + PAYLOAD_BYTES / 2;	// Coord word plus two bytes per pixel
	endfunction

	task automatic compare_byte(input string name, input logic [7:0] got,
		input logic [7:0] expected);
		if (got !== expected) begin
			value_errs++;
			$display("[ERROR] t=%0t %s: got %02h expected %02h", $time, name, got, expected);
		end
	endtask

	task automatic compare_word(input string name, input fifo_word_u got,
		input fifo_word_u expected);
		if (got !== expected) begin
			value_errs++;
			$display("[ERROR] t=%0t %s: got %012h expected %012h", $time, name, got,
				expected);
		end
	endtask

	task automatic compare_count(input string name, input int got, input int expected);
		if (got != expected) begin
			value_errs++;
			$display("[ERROR] t=%0t %s: got %0d expected %0d", $time, name, got, expected);
		end
	endtask

	//--------------------------------------------------------------------------
	// Reference models
	//--------------------------------------------------------------------------
	function automatic logic [15:0] ip_checksum(input logic [31:0] sip,
		input logic [31:0] dip);
		logic [31:0] sum;
		sum = 32'(IP_VER_TOS) + 32'(IP_TOTAL_LEN) + 32'(IP_IDEN) + 32'(IP_FLAGS) +
			32'({IP_TTL, IP_PROTO}) + 32'(sip[31:16]) + 32'(sip[15:0]) +
			32'(dip[31:16]) + 32'(dip[15:0]);
		while (sum[31:16] != 16'd0)
			sum = 32'(sum[15:0]) + 32'(sum[31:16]);	// End-around carry
		return ~sum[15:0];
	endfunction

	// MSB-first CRC-32, body bits fed LSB first as on the wire
	function automatic logic [31:0] ref_fcs(input int first, input int last);
		logic [31:0] crc;
		logic [31:0] fcs;
		logic        fb;
		crc = 32'hFFFF_FFFF;
		for (int i = first; i <= last; i++) begin
			for (int b = 0; b < 8; b++) begin
				fb  = crc[31] ^ exp_bytes[i][b];
				crc = {crc[30:0], 1'b0};
				if (fb)
					crc = crc ^ 32'h04C1_1DB7;
			end
		end
		for (int j = 0; j < 32; j++)
			fcs[j] = ~crc[31 - j];	// Wire byte k sits in fcs[8k +: 8]
		return fcs;
	endfunction

	task automatic push_field(input logic [47:0] value, input int nbytes);
		for (int i = nbytes - 1; i >= 0; i--)
			exp_bytes.push_back(value[i * 8 +: 8]);	// Network order
	endtask

	task automatic build_expected(input bit stn, input bit md);
		logic [31:0] sip;
		logic [31:0] dip;
		exp_bytes.delete();
		repeat (PREAMBLE_BYTES) exp_bytes.push_back(8'h55);
		exp_bytes.push_back(8'hD5);
		sip = {IP_SRC_ADDR[31:8], IP_SRC_ADDR[7:0] + 8'(stn)};
		dip = {IP_DST_ADDR[31:8], IP_DST_ADDR[7:0] - 8'(stn)};
		push_field({DST_MAC[47:8], DST_MAC[7:0] - 8'(stn)}, 6);
		push_field({SRC_MAC[47:8], SRC_MAC[7:0] + 8'(stn)}, 6);
		push_field(48'(ETH_TYPE), 2);
		push_field(48'(IP_VER_TOS), 2);
		push_field(48'(IP_TOTAL_LEN), 2);
		push_field(48'(IP_IDEN), 2);
		push_field(48'(IP_FLAGS), 2);
		push_field(48'({IP_TTL, IP_PROTO}), 2);
		push_field(48'(ip_checksum(sip, dip)), 2);
		push_field(48'(sip), 4);
		push_field(48'(dip), 4);
		push_field(48'(UDP_SRC_PORT), 2);
		push_field(48'(UDP_DST_PORT), 2);
		push_field(48'(UDP_LEN), 2);
		push_field(48'd0, 2);	// UDP checksum unused
		push_field(48'(cur_words[0].coord.line_y), 2);
		push_field(48'(cur_words[0].coord.line_x), 2);
		for (int i = 1; i < cur_words.size(); i++) begin
			exp_bytes.push_back(md ? cur_words[i].pixel.green : cur_words[i].pixel.luma);
			exp_bytes.push_back(md ? cur_words[i].pixel.red : cur_words[i].pixel.chroma);
		end
	endtask

	//--------------------------------------------------------------------------
	// Stimulus and capture
	//--------------------------------------------------------------------------
	task automatic fill_fifo(input int count);
		fifo_word_u w;
		@(negedge fifo_clk);	// Queue edits stay clear of the model's edge
		for (int i = 0; i < count; i++) begin
			w = {16'($random(seed)), 32'($random(seed))};
			fifo_q.push_back(w);
			exp_q.push_back(w);
		end
	endtask

	task automatic flush_fifo();
		@(negedge fifo_clk);
		fifo_q.delete();
		exp_q.delete();
		popped_q.delete();
	endtask

	task automatic pulse_line_write();
		@(posedge fifo_clk);
		fifo_wr_en <= 1'b1;
		@(posedge fifo_clk);
		fifo_wr_en <= 1'b0;	// Falling edge arms two frames
	endtask

	task automatic wait_tx_rise(input int limit, output bit found, output int rise_cyc);
		int n;
		n        = 0;
		found    = 1'b0;
		rise_cyc = 0;
		while (!found && n < limit) begin
			@(negedge fifo_clk);
			n++;
			if (tx_en) begin
				found    = 1'b1;
				rise_cyc = cyc;
			end
		end
	endtask

	task automatic capture_frame(output int rise_cyc, output int fall_cyc);
		bit found;
		int n;
		rx_bytes.delete();
		fall_cyc = 0;
		wait_tx_rise(3000, found, rise_cyc);
		if (!found) begin
			other_errs++;
			$display("t=%0t no frame started within 3000 cycles", $time);
		end else begin
			n = 0;
			while (tx_en && n < 2000) begin
				rx_bytes.push_back(txd);
				@(negedge fifo_clk);
				n++;
			end
			fall_cyc = cyc;
			if (tx_en) begin
				other_errs++;
				$display("t=%0t tx_en stayed high for 2000 cycles", $time);
			end
		end
	endtask

	task automatic check_frame(input bit stn, input bit md);
		logic [31:0] fcs;
		fifo_word_u  got;
		int          body_end;
		int          hdr_end;	// First coordinate byte
		int          pos;
		cur_words.delete();
		while (cur_words.size() < words_per_frame() && exp_q.size() > 0)
			cur_words.push_back(exp_q.pop_front());
		build_expected(stn, md);
		body_end = frame_len() - FCS_BYTES;
		hdr_end  = PREAMBLE_BYTES + 1 + HEADER_BYTES;
		compare_count("frame length", rx_bytes.size(), frame_len());
		compare_count("words popped", popped_q.size(), words_per_frame());
		if (rx_bytes.size() == frame_len() && cur_words.size() == words_per_frame()) begin
			for (int i = 0; i < hdr_end; i++)
				compare_byte($sformatf("txd[%0d]", i), rx_bytes[i], exp_bytes[i]);
			// Words rebuilt from the wire, unsent lanes as queued
			got              = cur_words[0];
			got.coord.line_y = {rx_bytes[hdr_end], rx_bytes[hdr_end + 1]};
			got.coord.line_x = {rx_bytes[hdr_end + 2], rx_bytes[hdr_end + 3]};
			compare_word("coord word", got, cur_words[0]);
			for (int i = 1; i < words_per_frame(); i++) begin
				pos = hdr_end + COORD_BYTES + 2 * (i - 1);
				got = cur_words[i];
				if (md) begin
					got.pixel.green = rx_bytes[pos];
					got.pixel.red   = rx_bytes[pos + 1];
				end else begin
					got.pixel.luma   = rx_bytes[pos];
					got.pixel.chroma = rx_bytes[pos + 1];
				end
				compare_word($sformatf("pixel word %0d", i), got, cur_words[i]);
			end
			fcs = ref_fcs(PREAMBLE_BYTES + 1, body_end - 1);	// Body after SFD
			for (int k = 0; k < FCS_BYTES; k++)
				compare_byte($sformatf("fcs[%0d]", k), rx_bytes[body_end + k], fcs[k * 8 +: 8]);
		end
		popped_q.delete();
	endtask

	task automatic check_gap(input int fall_a, input int rise_b);
		if (rise_b - fall_a < IFG_CYCLES) begin
			value_errs++;
			$display("[ERROR] t=%0t tx_en gap: got %0d expected at least %0d", $time,
				rise_b - fall_a, IFG_CYCLES);
		end
	endtask

	//--------------------------------------------------------------------------
	// Directed tests
	//--------------------------------------------------------------------------
	// No line write, no frame; one line write, two frames, YUV view
	task automatic test_line_gates_frames();
		int rise_a;
		int fall_a;
		int rise_b;
		int fall_b;
		int unused_cyc;
		bit found;
		fill_fifo(3 * words_per_frame());
		wait_tx_rise(200, found, unused_cyc);
		compare_count("frames before line write", int'(found), 0);
		pulse_line_write();
		capture_frame(rise_a, fall_a);
		check_frame(1'b0, 1'b0);
		capture_frame(rise_b, fall_b);
		check_frame(1'b0, 1'b0);
		check_gap(fall_a, rise_b);
		wait_tx_rise(200, found, unused_cyc);	// Third frame must not come
		compare_count("frames after two", int'(found), 0);
		flush_fifo();
	endtask

	// Armed while empty, so the start is the first non-empty cycle
	task automatic test_start_latency_raw();
		int start_cyc;
		int rise_a;
		int fall_a;
		int rise_b;
		int fall_b;
		int n;
		@(posedge fifo_clk);
		station_id <= 1'b1;
		mode       <= 1'b1;	// Green and red
		pulse_line_write();
		repeat (4) @(negedge fifo_clk);
		fill_fifo(2 * words_per_frame());
		n = 0;
		while (fifo_empty && n < 10) begin
			@(negedge fifo_clk);
			n++;
		end
		if (fifo_empty) begin
			other_errs++;
			$display("t=%0t FIFO model stayed empty after filling", $time);
		end
		start_cyc = cyc;
		capture_frame(rise_a, fall_a);
		compare_count("tx_en start latency", rise_a - start_cyc, 2);
		check_frame(1'b1, 1'b1);
		capture_frame(rise_b, fall_b);
		check_frame(1'b1, 1'b1);
		check_gap(fall_a, rise_b);
	endtask

	initial begin
		int total;
		sys_rst    = 1'b1;
		station_id = 1'b0;
		mode       = 1'b0;
		fifo_dout  = '0;
		fifo_empty = 1'b1;
		fifo_wr_en = 1'b0;
		cyc        = 0;
		value_errs = 0;
		other_errs = 0;
		seed       = 14;
		repeat (2) @(posedge fifo_clk);
		sys_rst <= 1'b0;
		test_line_gates_frames();
		test_start_latency_raw();
		total = value_errs + other_errs + gmii_udp_tx_inst.gmii_udp_tx_props_inst.assert_fails;
		$display("Error counts: %0d value, %0d other, %0d assertion", value_errs, other_errs,
			gmii_udp_tx_inst.gmii_udp_tx_props_inst.assert_fails);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* gmii_udp_tx.f */
verilog/gmii_udp_tx_pkg.sv
verilog/fifo_word_decode.sv
verilog/ip_header_gen.sv
verilog/frame_sequencer.sv
verilog/fcs_append.sv
verilog/gmii_udp_tx.sv
tb/gmii_udp_tx_props.sv
tb/gmii_udp_tx_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module gmii_udp_tx_tb \
		-f gmii_udp_tx.f -o gmii_udp_tx_sim
	./obj_dir/gmii_udp_tx_sim | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
